// ==== logic/luma_cost_macros.svh ====
`ifndef LUMA_COST_MACROS_SVH
`define LUMA_COST_MACROS_SVH

// ------------------------------------------------------------
// Block geometry
// ------------------------------------------------------------

// Signed coefficient width
`define COEF_W 16

// AC slots carried by one beat, one beat per 4x4 sub-block
`define AC_LANES 16

// Sub-blocks in one 16x16 luma macroblock
`define BEATS_PER_BLOCK 16

// ------------------------------------------------------------
// Accumulator widths
// ------------------------------------------------------------

// 17 squares of up to 2^30 each
`define ENERGY_W 36

// Reported block cost, saturating
`define COST_W 32

`endif

// ==== logic/luma_cost_pkg.sv ====
`include "luma_cost_macros.svh"

package luma_cost_pkg;

    // ------------------------------------------------------------
    // Datapath payloads
    // ------------------------------------------------------------

    // One 4x4 sub-block, lane 0 sits in the low bits of ac
    typedef struct packed {
        logic [`AC_LANES-1:0][`COEF_W-1:0] ac;
        logic [`COEF_W-1:0]                dc;
    } coef_beat_t;

    // Block cost as offered on the output port
    typedef struct packed {
        logic [`COST_W-1:0] cost;
        logic               saturated;
    } cost_result_t;

    // ------------------------------------------------------------
    // Controller
    // ------------------------------------------------------------

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_ACCUM  = 2'd1,
        ST_DRAIN  = 2'd2,
        ST_REPORT = 2'd3
    } ctrl_state_t;

endpackage

// ==== logic/cost_ctrl.sv ====
module cost_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    input  logic out_ready,
    input  logic last_beat,
    output logic in_ready,
    output logic take_beat,
    output logic clear_acc,
    output logic out_valid
);

    import luma_cost_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;

    // ------------------------------------------------------------
    // Handshake decode
    // ------------------------------------------------------------

    // Input open only while a block is being collected
    assign in_ready  = (state == ST_IDLE) || (state == ST_ACCUM);
    assign take_beat = in_valid && in_ready;

    // Total is final once DRAIN has passed, so valid is a pure state decode
    assign out_valid = (state == ST_REPORT);

    // Output transfer completes, start the next block from zero
    assign clear_acc = out_valid && out_ready;

    // ------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (take_beat) begin
                    state_next = last_beat ? ST_DRAIN : ST_ACCUM;
                end
            end
            ST_ACCUM: begin
                if (take_beat && last_beat) begin
                    state_next = ST_DRAIN;
                end
            end
            // One cycle for the last energy to reach the accumulator
            ST_DRAIN: begin
                state_next = ST_REPORT;
            end
            // Back-pressure parks here, input stays closed
            ST_REPORT: begin
                if (out_ready) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------
    // State register
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== logic/subblock_counter.sv ====
`include "luma_cost_macros.svh"

module subblock_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic take_beat,
    output logic last_beat
);

    localparam int CNT_W = $clog2(`BEATS_PER_BLOCK);
    localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(`BEATS_PER_BLOCK - 1);

    // Index of the sub-block expected next
    logic [CNT_W-1:0] beat_idx;

    // High while the next accepted beat closes the macroblock
    assign last_beat = (beat_idx == LAST_IDX);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_idx <= '0;
        end else if (take_beat) begin
            if (last_beat) begin
                // Wrap for the next macroblock
                beat_idx <= '0;
            end else begin
                beat_idx <= beat_idx + 1'b1;
            end
        end
    end

endmodule

// ==== logic/subblock_energy.sv ====
`include "luma_cost_macros.svh"

module subblock_energy (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      take_beat,
    input  luma_cost_pkg::coef_beat_t in_beat,
    output logic [`ENERGY_W-1:0]      energy,
    output logic                      energy_valid
);

    localparam int SQ_W = 2 * `COEF_W;

    logic [`ENERGY_W-1:0] energy_sum;

    // ------------------------------------------------------------
    // Square of one signed coefficient
    // ------------------------------------------------------------

    // Never negative and -32768 gives exactly 2^30
    function automatic logic [SQ_W-1:0] square(input logic signed [`COEF_W-1:0] c);
        logic signed [SQ_W-1:0] prod;
        prod = SQ_W'(c) * SQ_W'(c);
        return prod;
    endfunction

    // ------------------------------------------------------------
    // Sum of 16 AC squares and the DC square
    // ------------------------------------------------------------

    always_comb begin
        energy_sum = `ENERGY_W'(square(in_beat.dc));
        for (int i = 0; i < `AC_LANES; i++) begin
            energy_sum = energy_sum + `ENERGY_W'(square(in_beat.ac[i]));
        end
    end

    // ------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------

    // Valid for one cycle per accepted beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            energy_valid <= 1'b0;
        end else begin
            energy_valid <= take_beat;
        end
    end

    // Sum only captured on an accept
    always_ff @(posedge clk) begin
        if (take_beat) begin
            energy <= energy_sum;
        end
    end

endmodule

// ==== logic/cost_accum.sv ====
`include "luma_cost_macros.svh"

module cost_accum (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`ENERGY_W-1:0]        energy,
    input  logic                        energy_valid,
    input  logic                        clear_acc,
    output luma_cost_pkg::cost_result_t result
);

    // One spare bit so the carry out of the add is never lost
    localparam int SUM_W = `ENERGY_W + 1;
    localparam logic [`COST_W-1:0] COST_MAX = '1;

    logic [`COST_W-1:0] total;
    logic               saturated;
    logic [SUM_W-1:0]   sum_wide;
    logic               overflow;

    assign sum_wide = SUM_W'(total) + SUM_W'(energy);
    assign overflow = (sum_wide > SUM_W'(COST_MAX));

    // ------------------------------------------------------------
    // Running total
    // ------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            total     <= '0;
            saturated <= 1'b0;
        end else if (clear_acc) begin
            total     <= '0;
            saturated <= 1'b0;
        end else if (energy_valid) begin
            if (overflow) begin
                // Pin at the top, flag sticks until clear
                total     <= COST_MAX;
                saturated <= 1'b1;
            end else begin
                total <= sum_wide[`COST_W-1:0];
            end
        end
    end

    assign result = '{cost: total, saturated: saturated};

endmodule

// ==== logic/luma_cost_top.sv ====
`include "luma_cost_macros.svh"

module luma_cost_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  luma_cost_pkg::coef_beat_t   in_beat,
    output logic                        out_valid,
    input  logic                        out_ready,
    output luma_cost_pkg::cost_result_t out_cost
);

    logic                 take_beat;
    logic                 clear_acc;
    logic                 last_beat;
    logic [`ENERGY_W-1:0] energy;
    logic                 energy_valid;

    // ------------------------------------------------------------
    // Control
    // ------------------------------------------------------------

    cost_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .out_ready (out_ready),
        .last_beat (last_beat),
        .in_ready  (in_ready),
        .take_beat (take_beat),
        .clear_acc (clear_acc),
        .out_valid (out_valid)
    );

    subblock_counter u_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .take_beat (take_beat),
        .last_beat (last_beat)
    );

    // ------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------

    subblock_energy u_energy (
        .clk          (clk),
        .rst_n        (rst_n),
        .take_beat    (take_beat),
        .in_beat      (in_beat),
        .energy       (energy),
        .energy_valid (energy_valid)
    );

    // Result held steady while REPORT waits on out_ready
    cost_accum u_accum (
        .clk          (clk),
        .rst_n        (rst_n),
        .energy       (energy),
        .energy_valid (energy_valid),
        .clear_acc    (clear_acc),
        .result       (out_cost)
    );

endmodule

// ==== tb/tb_clkgen.sv ====
module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

    always #HALF_PERIOD clk = ~clk;

endmodule

// ==== tb/tb_luma_cost.sv ====
`include "luma_cost_macros.svh"

module tb_luma_cost;

    import luma_cost_pkg::*;

    localparam int          N_CASES     = 7;
    localparam int          CYCLE_LIMIT = N_CASES * 40;
    localparam int unsigned SEED        = 32'h4971_c2a4;

    typedef enum logic [2:0] {
        FILL_ZERO,
        FILL_CONST,
        FILL_MAX_NEG,
        FILL_DC_ONLY,
        FILL_RANDOM
    } fill_t;

    // Cost and sat only matter for directed rows
    typedef struct packed {
        fill_t              kind;
        logic [`COEF_W-1:0] value;
        int                 gap;
        int                 stall;
        logic [`COST_W-1:0] cost;
        logic               sat;
    } case_t;

    logic         clk;
    logic         rst_n;
    logic         in_valid;
    logic         in_ready;
    coef_beat_t   in_beat;
    logic         out_valid;
    logic         out_ready;
    cost_result_t out_cost;

    case_t              cases [N_CASES];
    coef_beat_t         beats [`BEATS_PER_BLOCK];
    logic [`COST_W-1:0] exp_cost;
    logic               exp_sat;
    int                 cycle_count = 0;
    int                 last_accept = 0;
    int                 errors = 0;
    int                 checks = 0;

    tb_clkgen u_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    luma_cost_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_cost  (out_cost)
    );

    // ------------------------------------------------------------
    // Stimulus table and reference model
    // ------------------------------------------------------------

    task automatic load_cases();
        // kind, value, gap, stall, cost, sat
        cases[0] = '{FILL_ZERO,    16'h0000, 0, 0, 32'h0000_0000, 1'b0};
        cases[1] = '{FILL_CONST,   16'h0064, 1, 0, 32'h0029_8100, 1'b0};
        cases[2] = '{FILL_MAX_NEG, 16'h8000, 0, 3, 32'hFFFF_FFFF, 1'b1};
        cases[3] = '{FILL_DC_ONLY, 16'h03E8, 0, 0, 32'h00F4_2400, 1'b0};
        // Value is the coefficient span on random rows
        cases[4] = '{FILL_RANDOM,  16'd2000, 2, 0, 32'h0000_0000, 1'b0};
        cases[5] = '{FILL_RANDOM,  16'd8000, 1, 4, 32'h0000_0000, 1'b0};
        cases[6] = '{FILL_RANDOM,  16'd300,  0, 2, 32'h0000_0000, 1'b0};
    endtask

    function automatic logic [`COEF_W-1:0] pick_coef(input case_t c, input bit is_dc);
        int span;
        span = int'(c.value);
        case (c.kind)
            FILL_CONST:   return c.value;
            FILL_MAX_NEG: return 16'h8000;
            FILL_DC_ONLY: return is_dc ? c.value : 16'h0000;
            FILL_RANDOM:  return 16'(int'($urandom_range(2 * span)) - span);
            default:      return 16'h0000;
        endcase
    endfunction

    // Fill the 16 beats and work out the expected cost
    task automatic build_block(input int row);
        longint v;
        longint sum;
        sum = 0;
        for (int b = 0; b < `BEATS_PER_BLOCK; b++) begin
            for (int i = 0; i < `AC_LANES; i++) begin
                beats[b].ac[i] = pick_coef(cases[row], 1'b0);
                v = longint'($signed(beats[b].ac[i]));
                sum = sum + v * v;
            end
            beats[b].dc = pick_coef(cases[row], 1'b1);
            v = longint'($signed(beats[b].dc));
            sum = sum + v * v;
        end
        if (cases[row].kind == FILL_RANDOM) begin
            exp_sat  = (sum > 64'h0000_0000_FFFF_FFFF);
            exp_cost = exp_sat ? 32'hFFFF_FFFF : sum[31:0];
        end else begin
            exp_cost = cases[row].cost;
            exp_sat  = cases[row].sat;
        end
    endtask

    task automatic expect_equal(input string name, input int row,
                                input logic [31:0] got, input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("ERR %s row %0d: got %h expected %h", name, row, got, want);
        end
    endtask

    // ------------------------------------------------------------
    // Input and output sides
    // ------------------------------------------------------------

    task automatic drive_block(input int row);
        for (int b = 0; b < `BEATS_PER_BLOCK; b++) begin
            repeat (cases[row].gap) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
            @(posedge clk);
            in_valid <= 1'b1;
            in_beat  <= beats[b];
            // Valid held until the beat is taken
            @(negedge clk);
            while (!in_ready) @(negedge clk);
            last_accept = cycle_count;
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic collect_result(input int row);
        cost_result_t held;
        do @(negedge clk); while (!out_valid);
        expect_equal("out_valid latency", row, 32'(cycle_count - last_accept), 32'd2);
        held = out_cost;
        for (int s = 0; s < cases[row].stall; s++) begin
            expect_equal("in_ready", row, 32'(in_ready), 32'd0);
            @(posedge clk);
            if (s == cases[row].stall - 1) begin
                out_ready <= 1'b1;
            end
            @(negedge clk);
            // Offer stays up while the sink stalls
            expect_equal("out_valid", row, 32'(out_valid), 32'd1);
            expect_equal("out_cost.cost", row, out_cost.cost, held.cost);
            expect_equal("out_cost.saturated", row, 32'(out_cost.saturated),
                         32'(held.saturated));
        end
        expect_equal("in_ready", row, 32'(in_ready), 32'd0);
        expect_equal("out_cost.cost", row, out_cost.cost, exp_cost);
        expect_equal("out_cost.saturated", row, 32'(out_cost.saturated), 32'(exp_sat));
        @(posedge clk);
        out_ready <= 1'b0;
        // Input opens again after the transfer
        @(negedge clk);
        expect_equal("out_valid", row, 32'(out_valid), 32'd0);
        expect_equal("in_ready", row, 32'(in_ready), 32'd1);
    endtask

    // ------------------------------------------------------------
    // Run control
    // ------------------------------------------------------------

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: no result after %0d cycles, a handshake never completed",
                     cycle_count);
            $display("Closing: %0d errors in %0d checks", errors, checks);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        in_valid  = 1'b0;
        out_ready = 1'b0;
        in_beat   = '0;
        void'($urandom(SEED));
        load_cases();
        wait (rst_n == 1'b1);
        @(negedge clk);
        expect_equal("in_ready", -1, 32'(in_ready), 32'd1);
        expect_equal("out_valid", -1, 32'(out_valid), 32'd0);
        for (int r = 0; r < N_CASES; r++) begin
            build_block(r);
            @(posedge clk);
            out_ready <= (cases[r].stall == 0);
            fork
                drive_block(r);
                collect_result(r);
            join
        end
        $display("Closing: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+logic
logic/luma_cost_pkg.sv
logic/cost_ctrl.sv
logic/subblock_counter.sv
logic/subblock_energy.sv
logic/cost_accum.sv
logic/luma_cost_top.sv
tb/tb_clkgen.sv
tb/tb_luma_cost.sv

// ==== Makefile ====
SIM       := verilator
SIM_FLAGS := --binary --timing -j 0
TOP       := tb_luma_cost
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
PASS_MSG  := All checks passed

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) logic/luma_cost_macros.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
